//--- eccMem.f
hsiaoEccPkg.sv
hsiaoEccEnc.sv
hsiaoEccDec.sv
eccSramBank.sv
eccMemCtrl.sv
eccMemTop.sv
eccMemTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal
TOP       ?= eccMemTb
FILELIST  ?= eccMem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- eccMemTb.sv
// Directed testbench module eccMemTb with clock, reset, reference model, checks and timeout
`timescale 1ns/1ns

module eccMemTb;

  localparam int unsigned AddrWidth  = hsiaoEccPkg::MemAddrWidth;
  localparam int unsigned DataWidth  = hsiaoEccPkg::MemDataWidth;
  localparam int unsigned ProtWidth  = hsiaoEccPkg::MemProtWidth;
  localparam int unsigned TotalWidth = hsiaoEccPkg::MemTotalWidth;
  // The sequence takes a little over 900 cycles, most of them in the saturation reads
  localparam int unsigned TimeoutCycles = 1500;

  logic                               clk_i;
  logic                               rstN;
  logic                               reqValid;
  hsiaoEccPkg::memReqT                req;
  logic                               rspValid;
  hsiaoEccPkg::memRspT                rsp;
  logic [hsiaoEccPkg::CountWidth-1:0] correctedCount;
  logic [hsiaoEccPkg::CountWidth-1:0] uncorrectableCount;

  // Reference model, written data plus the flips still present in each stored codeword
  logic [DataWidth-1:0]  shadowMem [2**AddrWidth];
  logic [TotalWidth-1:0] storedMask [2**AddrWidth];
  bit [hsiaoEccPkg::MaxParityWidth-1:0][hsiaoEccPkg::MaxTotalWidth-1:0] parityMatrix;
  int unsigned expCorrected;
  int unsigned expUncorrectable;
  int unsigned cycleCount;

  eccMemTop #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .ProtWidth(ProtWidth)
  ) eccMemTop_i (
    .clk_i             (clk_i),
    .rstN              (rstN),
    .reqValid          (reqValid),
    .req               (req),
    .rspValid          (rspValid),
    .rsp               (rsp),
    .correctedCount    (correctedCount),
    .uncorrectableCount(uncorrectableCount)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("TIMEOUT: the test sequence did not end within %0d cycles", TimeoutCycles);
      stopWithFailure();
    end
  end

  task automatic stopWithFailure();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic failWithReason(string reason);
    $display("ERROR at %0t ns: %s", $time, reason);
    stopWithFailure();
  endtask

  task automatic checkValue(string name, logic [63:0] actual, logic [63:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      stopWithFailure();
    end
  endtask

  // Inputs change and outputs are sampled 2 ns after each rising edge
  task automatic nextCycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic driveIdle();
    reqValid = 1'b0;
    req      = '0;
  endtask

  // Syndrome of a flip at one codeword position is that position's matrix column
  function automatic logic [ProtWidth-1:0] predictSyndrome(logic [TotalWidth-1:0] mask);
    logic [ProtWidth-1:0] syn;
    syn = '0;
    for (int b = 0; b < TotalWidth; b++) begin
      for (int r = 0; r < ProtWidth; r++) begin
        syn[r] ^= mask[b] & parityMatrix[r][b];
      end
    end
    return syn;
  endfunction

  task automatic storeWord(int unsigned addr, logic [DataWidth-1:0] data,
                           logic [TotalWidth-1:0] mask);
    reqValid         = 1'b1;
    req.write        = 1'b1;
    req.addr         = addr;
    req.writeData    = data;
    req.flipMask     = mask;
    shadowMem[addr]  = data;
    storedMask[addr] = mask;
    nextCycle();
    driveIdle();
  endtask

  task automatic issueRead(int unsigned addr);
    reqValid  = 1'b1;
    req.write = 1'b0;
    req.addr  = addr;
  endtask

  // Checks the response now on the outputs against the model of one address
  task automatic checkResponse(int unsigned addr);
    logic [TotalWidth-1:0] mask;
    logic [DataWidth-1:0]  expData;
    hsiaoEccPkg::eccErrT   expErr;
    mask    = storedMask[addr];
    expData = shadowMem[addr];
    expErr  = ($countones(mask) == 1) ? 2'b01 : ($countones(mask) == 2) ? 2'b10 : 2'b00;
    // A double error leaves the raw data bits uncorrected
    if (expErr == 2'b10) begin
      expData ^= mask[DataWidth-1:0];
    end
    if (!rspValid) begin
      failWithReason($sformatf("no response 2 cycles after the read of address %0d", addr));
    end
    checkValue("rsp.readData", rsp.readData, expData);
    checkValue("rsp.syndrome", rsp.syndrome, predictSyndrome(mask));
    checkValue("rsp.err", rsp.err, expErr);
    if (expErr == 2'b01 && expCorrected < 255) begin
      expCorrected++;
    end
    if (expErr == 2'b10 && expUncorrectable < 255) begin
      expUncorrectable++;
    end
    // The corrected write-back repairs the stored codeword
    if (expErr == 2'b01) begin
      storedMask[addr] = '0;
    end
    checkValue("correctedCount", correctedCount, expCorrected);
    checkValue("uncorrectableCount", uncorrectableCount, expUncorrectable);
  endtask

  task automatic readAndCheck(int unsigned addr);
    issueRead(addr);
    nextCycle();
    driveIdle();
    for (int i = 0; i < 2; i++) begin
      if (rspValid) begin
        failWithReason($sformatf("response pulse before the read of address %0d was due", addr));
      end
      nextCycle();
    end
    checkResponse(addr);
  endtask

  task automatic testCleanTraffic();
    checkValue("correctedCount", correctedCount, 0);
    checkValue("uncorrectableCount", uncorrectableCount, 0);
    for (int a = 0; a < 16; a++) begin
      storeWord(a, $urandom(), '0);
    end
    for (int a = 0; a < 16; a++) begin
      readAndCheck(a);
    end
  endtask

  task automatic testSingleCorrection();
    int unsigned positions [6] = '{0, 7, 19, 31, 32, 38};
    for (int i = 0; i < 6; i++) begin
      storeWord(16 + i, $urandom(), TotalWidth'(1) << positions[i]);
      readAndCheck(16 + i);
    end
  endtask

  task automatic testWriteBack();
    // Data bit and parity bit cases from the correction test, already rewritten
    readAndCheck(16);
    readAndCheck(21);
    storeWord(24, $urandom(), TotalWidth'(1) << 5);
    issueRead(24);
    nextCycle();
    driveIdle();
    nextCycle();
    // This host write is taken on the response edge and takes the port from the write-back
    storeWord(25, $urandom(), '0);
    checkResponse(24);
    storedMask[24] = TotalWidth'(1) << 5;
    readAndCheck(24);
    readAndCheck(24);
    readAndCheck(25);
  endtask

  task automatic testDoubleDetection();
    storeWord(30, $urandom(), (TotalWidth'(1) << 3) | (TotalWidth'(1) << 35));
    storeWord(31, $urandom(), (TotalWidth'(1) << 10) | (TotalWidth'(1) << 20));
    for (int a = 30; a < 32; a++) begin
      readAndCheck(a);
      // No write-back, so the same error shows again
      readAndCheck(a);
    end
  endtask

  task automatic testBackToBack();
    for (int i = 0; i < 6; i++) begin
      storeWord(40 + i, $urandom(), (i % 2 == 1) ? TotalWidth'(1) << (i * 7) : '0);
    end
    for (int t = 0; t < 8; t++) begin
      if (t < 6) begin
        issueRead(40 + t);
      end
      nextCycle();
      driveIdle();
      if (t >= 2) begin
        checkResponse(40 + t - 2);
      end else if (rspValid) begin
        failWithReason("response pulse before the first burst read was due");
      end
    end
    nextCycle();
    if (rspValid) begin
      failWithReason("extra response pulse after the burst of reads");
    end
  endtask

  task automatic testCounterSaturation();
    storeWord(50, $urandom(), (TotalWidth'(1) << 1) | (TotalWidth'(1) << 2));
    while (expUncorrectable < 255) begin
      readAndCheck(50);
    end
    repeat (3) begin
      readAndCheck(50);
    end
  endtask

  initial begin
    void'($urandom(58949));
    parityMatrix     = hsiaoEccPkg::hsiao_matrix(DataWidth, ProtWidth);
    expCorrected     = 0;
    expUncorrectable = 0;
    cycleCount       = 0;
    rstN             = 1'b0;
    driveIdle();
    repeat (2) begin
      @(posedge clk_i);
    end
    #2;
    rstN = 1'b1;
    testCleanTraffic();
    testSingleCorrection();
    testWriteBack();
    testDoubleDetection();
    testBackToBack();
    testCounterSaturation();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- eccMemTop.sv
// Top level module eccMemTop joining the controller, encoder, storage bank and decoder
`timescale 1ns/1ns

module eccMemTop #(
  parameter int unsigned AddrWidth = hsiaoEccPkg::MemAddrWidth,
  parameter int unsigned DataWidth = hsiaoEccPkg::MemDataWidth,
  parameter int unsigned ProtWidth = hsiaoEccPkg::MemProtWidth
) (
  input  logic                               clk_i,
  input  logic                               rstN,
  input  logic                               reqValid,
  input  hsiaoEccPkg::memReqT                req,
  output logic                               rspValid,
  output hsiaoEccPkg::memRspT                rsp,
  output logic [hsiaoEccPkg::CountWidth-1:0] correctedCount,
  output logic [hsiaoEccPkg::CountWidth-1:0] uncorrectableCount
);

  logic [          DataWidth-1:0] encData;
  logic [DataWidth+ProtWidth-1:0] encWord;
  logic                           writeEn;
  logic [          AddrWidth-1:0] writeAddr;
  logic [DataWidth+ProtWidth-1:0] writeWord;
  logic                           readEn;
  logic [          AddrWidth-1:0] readAddr;
  logic [DataWidth+ProtWidth-1:0] readWord;
  logic [          DataWidth-1:0] decData;
  logic [          ProtWidth-1:0] decSyndrome;
  hsiaoEccPkg::eccErrT            decErr;

  eccMemCtrl #(
    .AddrWidth(AddrWidth),
    .DataWidth(DataWidth),
    .ProtWidth(ProtWidth)
  ) eccMemCtrl_i (
    .clk_i             (clk_i),
    .rstN              (rstN),
    .reqValid          (reqValid),
    .req               (req),
    .encWord           (encWord),
    .decData           (decData),
    .decSyndrome       (decSyndrome),
    .decErr            (decErr),
    .encData           (encData),
    .writeEn           (writeEn),
    .writeAddr         (writeAddr),
    .writeWord         (writeWord),
    .readEn            (readEn),
    .readAddr          (readAddr),
    .rspValid          (rspValid),
    .rsp               (rsp),
    .correctedCount    (correctedCount),
    .uncorrectableCount(uncorrectableCount)
  );

  // Shared by host writes and corrected write-backs
  hsiaoEccEnc #(
    .DataWidth(DataWidth),
    .ProtWidth(ProtWidth)
  ) hsiaoEccEnc_i (
    .data    (encData),
    .codeword(encWord)
  );

  eccSramBank #(
    .AddrWidth(AddrWidth),
    .WordWidth(DataWidth + ProtWidth)
  ) eccSramBank_i (
    .clk_i    (clk_i),
    .writeEn  (writeEn),
    .writeAddr(writeAddr),
    .writeWord(writeWord),
    .readEn   (readEn),
    .readAddr (readAddr),
    .readWord (readWord)
  );

  // Decodes the registered bank output in the second read stage
  hsiaoEccDec #(
    .DataWidth(DataWidth),
    .ProtWidth(ProtWidth)
  ) hsiaoEccDec_i (
    .codeword(readWord),
    .data    (decData),
    .syndrome(decSyndrome),
    .err     (decErr)
  );

endmodule

//--- eccMemCtrl.sv
// Memory controller module eccMemCtrl with read pipeline, write-back and error counters
`timescale 1ns/1ns

module eccMemCtrl #(
  parameter int unsigned AddrWidth = hsiaoEccPkg::MemAddrWidth,
  parameter int unsigned DataWidth = hsiaoEccPkg::MemDataWidth,
  parameter int unsigned ProtWidth = hsiaoEccPkg::MemProtWidth
) (
  input  logic                                clk_i,
  input  logic                                rstN,
  input  logic                                reqValid,
  input  hsiaoEccPkg::memReqT                 req,
  input  logic [      DataWidth+ProtWidth-1:0] encWord,
  input  logic [                DataWidth-1:0] decData,
  input  logic [                ProtWidth-1:0] decSyndrome,
  input  hsiaoEccPkg::eccErrT                 decErr,
  output logic [                DataWidth-1:0] encData,
  output logic                                writeEn,
  output logic [                AddrWidth-1:0] writeAddr,
  output logic [      DataWidth+ProtWidth-1:0] writeWord,
  output logic                                readEn,
  output logic [                AddrWidth-1:0] readAddr,
  output logic                                rspValid,
  output hsiaoEccPkg::memRspT                 rsp,
  output logic [hsiaoEccPkg::CountWidth-1:0]  correctedCount,
  output logic [hsiaoEccPkg::CountWidth-1:0]  uncorrectableCount
);

  // Request and response structs are sized by the package constants
  if (AddrWidth != hsiaoEccPkg::MemAddrWidth || DataWidth != hsiaoEccPkg::MemDataWidth ||
      ProtWidth != hsiaoEccPkg::MemProtWidth) begin : genStructWidthCheck
    $error("Module widths must match the request and response structs");
  end

  logic                 hostWrite;
  logic                 hostRead;
  logic                 writeBack;
  // Second read stage, lines up with the bank output
  logic                 pipeValid;
  logic                 pipeStale;
  logic [AddrWidth-1:0] pipeAddr;

  assign hostWrite = reqValid & req.write;
  assign hostRead  = reqValid & ~req.write;

  // Corrected data goes back to memory unless a newer host write to the same address
  // already sits between the read and the write-back
  assign writeBack = pipeValid & decErr[0] & ~pipeStale;

  // One shared encoder, the host write has priority over the write-back
  assign encData = hostWrite ? req.writeData : decData;

  // Control state
  always_ff @(posedge clk_i or negedge rstN) begin
    if (!rstN) begin
      readEn             <= 1'b0;
      pipeValid          <= 1'b0;
      pipeStale          <= 1'b0;
      rspValid           <= 1'b0;
      writeEn            <= 1'b0;
      correctedCount     <= '0;
      uncorrectableCount <= '0;
    end else begin
      // First stage, the bank reads on the next edge
      readEn    <= hostRead;
      pipeValid <= readEn;
      // A host write to the read address arriving now lands in memory before the write-back
      pipeStale <= readEn & hostWrite & (req.addr == readAddr);
      rspValid  <= pipeValid;
      // The host write wins the port when both want it
      writeEn   <= hostWrite | writeBack;
      // Counters move on the same edge that registers the response
      if (pipeValid && decErr[0] && correctedCount != '1) begin
        correctedCount <= correctedCount + 1'b1;
      end
      if (pipeValid && decErr[1] && uncorrectableCount != '1) begin
        uncorrectableCount <= uncorrectableCount + 1'b1;
      end
    end
  end

  // Addresses and data words
  always_ff @(posedge clk_i) begin
    if (hostRead) begin
      readAddr <= req.addr;
    end
    if (readEn) begin
      pipeAddr <= readAddr;
    end
    if (pipeValid) begin
      rsp.readData <= decData;
      rsp.syndrome <= decSyndrome;
      rsp.err      <= decErr;
    end
    if (hostWrite) begin
      writeAddr <= req.addr;
      // Fault injection flips the selected codeword bits on the way into memory
      writeWord <= encWord ^ req.flipMask;
    end else if (writeBack) begin
      writeAddr <= pipeAddr;
      writeWord <= encWord;
    end
  end

endmodule

//--- eccSramBank.sv
// Codeword storage module eccSramBank with one write port and one registered read port
`timescale 1ns/1ns

module eccSramBank #(
  parameter int unsigned AddrWidth = hsiaoEccPkg::MemAddrWidth,
  parameter int unsigned WordWidth = hsiaoEccPkg::MemTotalWidth
) (
  input  logic                 clk_i,
  input  logic                 writeEn,
  input  logic [AddrWidth-1:0] writeAddr,
  input  logic [WordWidth-1:0] writeWord,
  input  logic                 readEn,
  input  logic [AddrWidth-1:0] readAddr,
  output logic [WordWidth-1:0] readWord
);

  // One codeword per address, contents are undefined until written
  logic [WordWidth-1:0] memArray [2**AddrWidth];

  // Write takes effect on the edge where writeEn is high
  always_ff @(posedge clk_i) begin
    if (writeEn) begin
      memArray[writeAddr] <= writeWord;
    end
  end

  // Registered read with old-data behavior on a same-edge write to the same address.
  // readWord holds its value while no read is issued
  always_ff @(posedge clk_i) begin
    if (readEn) begin
      readWord <= memArray[readAddr];
    end
  end

endmodule

//--- hsiaoEccDec.sv
// Combinational Hsiao SEC-DED decoder module hsiaoEccDec
`timescale 1ns/1ns

module hsiaoEccDec #(
  parameter int unsigned DataWidth = hsiaoEccPkg::MemDataWidth,
  parameter int unsigned ProtWidth = hsiaoEccPkg::MemProtWidth
) (
  input  logic [DataWidth+ProtWidth-1:0] codeword,
  output logic [          DataWidth-1:0] data,
  output logic [          ProtWidth-1:0] syndrome,
  output hsiaoEccPkg::eccErrT            err
);

  localparam int unsigned TotalWidth = DataWidth + ProtWidth;

  // Too few parity bits leave no room for distinct odd-weight columns
  if (ProtWidth < $clog2(DataWidth) + 2) begin : genProtWidthCheck
    $error("ProtWidth must be at least $clog2(DataWidth)+2");
  end

  localparam bit [hsiaoEccPkg::MaxParityWidth-1:0][hsiaoEccPkg::MaxTotalWidth-1:0] HsiaoCodes =
    hsiaoEccPkg::hsiao_matrix(DataWidth, ProtWidth);

  // Column of each codeword bit, the syndrome a flip of that bit produces
  localparam bit [hsiaoEccPkg::MaxTotalWidth-1:0][hsiaoEccPkg::MaxParityWidth-1:0] CorrCodes =
    hsiaoEccPkg::transpose(HsiaoCodes, ProtWidth, TotalWidth);

  logic singleError;

  // Syndrome recomputes each parity check over the full codeword, stored parity included
  for (genvar i = 0; i < ProtWidth; i++) begin : genSyndrome
    assign syndrome[i] = ^(codeword & HsiaoCodes[i][TotalWidth-1:0]);
  end

  // Only data bits are corrected since parity bits are not returned.
  // All columns are distinct, so at most one bit matches
  for (genvar i = 0; i < DataWidth; i++) begin : genCorrect
    assign data[i] = codeword[i] ^ (syndrome == CorrCodes[i][ProtWidth-1:0]);
  end

  // Every column has odd weight, so one flip gives an odd syndrome
  assign singleError = ^syndrome;

  // Two flips cancel to an even weight, which is never zero for distinct columns
  assign err[0] = singleError;
  assign err[1] = ~singleError & (|syndrome);

endmodule

//--- hsiaoEccEnc.sv
// Combinational Hsiao SEC-DED encoder module hsiaoEccEnc
`timescale 1ns/1ns

module hsiaoEccEnc #(
  parameter int unsigned DataWidth = hsiaoEccPkg::MemDataWidth,
  parameter int unsigned ProtWidth = hsiaoEccPkg::MemProtWidth
) (
  input  logic [          DataWidth-1:0] data,
  output logic [DataWidth+ProtWidth-1:0] codeword
);

  // Same matrix the decoder builds, evaluated at elaboration
  localparam bit [hsiaoEccPkg::MaxParityWidth-1:0][hsiaoEccPkg::MaxTotalWidth-1:0] HsiaoCodes =
    hsiaoEccPkg::hsiao_matrix(DataWidth, ProtWidth);

  logic [ProtWidth-1:0] parity;

  // Each parity bit covers the data bits selected in its row.
  // The parity columns are unit vectors so they play no part here
  for (genvar i = 0; i < ProtWidth; i++) begin : genParity
    assign parity[i] = ^(data & HsiaoCodes[i][DataWidth-1:0]);
  end

  // Systematic code, data passes through unchanged in the low bits
  assign codeword = {parity, data};

endmodule

//--- hsiaoEccPkg.sv
// Memory constants, request and response structs, Hsiao matrix and transpose functions
package hsiaoEccPkg;

  // Data word width seen by the host
  localparam int unsigned MemDataWidth = 32;

  // Minimum parity width for SEC-DED over the data word
  localparam int unsigned MemProtWidth = $clog2(MemDataWidth) + 2;

  // Stored codeword width, parity bits sit above the data bits
  localparam int unsigned MemTotalWidth = MemDataWidth + MemProtWidth;

  // Word address width, 64 words deep
  localparam int unsigned MemAddrWidth = 6;

  // Upper bounds for the matrix constants, enough for a 64-bit data word
  localparam int unsigned MaxParityWidth = 8;
  localparam int unsigned MaxTotalWidth  = 72;

  // Width of the saturating event counters
  localparam int unsigned CountWidth = 8;

  // Error flag, bit 0 is a corrected single error and bit 1 a detected double error
  typedef logic [1:0] eccErrT;

  // Host request, a read when write is low
  typedef struct packed {
    logic                     write;
    logic [MemAddrWidth-1:0]  addr;
    logic [MemDataWidth-1:0]  writeData;
    // XORed into the encoded codeword before it is stored
    logic [MemTotalWidth-1:0] flipMask;
  } memReqT;

  // Read response with the corrected data and the decoder status
  typedef struct packed {
    logic [MemDataWidth-1:0] readData;
    logic [MemProtWidth-1:0] syndrome;
    eccErrT                  err;
  } memRspT;

  // Builds the parity-check matrix, one row per parity bit and one column per codeword bit.
  // Parity bits get unit columns. Every data bit gets a distinct odd-weight column of weight
  // three or more, and among the candidates of the lowest free weight the one that loads the
  // lightest rows is taken, so the XOR trees stay roughly balanced
  function automatic bit [MaxParityWidth-1:0][MaxTotalWidth-1:0] hsiao_matrix(
    int unsigned dataWidth,
    int unsigned protWidth
  );
    bit [MaxParityWidth-1:0][MaxTotalWidth-1:0] mat;
    bit [(2**MaxParityWidth)-1:0]               used;
    int unsigned                                weight;
    int unsigned                                cost;
    int unsigned                                bestCost;
    int                                         best;

    mat    = '0;
    used   = '0;
    weight = 3;

    // Identity part for the parity bits
    for (int p = 0; p < protWidth; p++) begin
      mat[p][dataWidth+p] = 1'b1;
    end

    for (int d = 0; d < dataWidth; d++) begin
      best = 0;
      // Move to the next odd weight once the current one has no free column left
      while (best == 0 && weight <= protWidth) begin
        bestCost = '1;
        for (int v = 1; v < 2**protWidth; v++) begin
          if (!used[v] && $countones(v) == weight) begin
            cost = 0;
            // Each row holds one parity bit, so its popcount tracks the data load
            for (int r = 0; r < protWidth; r++) begin
              if (v[r]) begin
                cost += $countones(mat[r]);
              end
            end
            if (cost < bestCost) begin
              bestCost = cost;
              best     = v;
            end
          end
        end
        if (best == 0) begin
          weight += 2;
        end
      end
      used[best] = 1'b1;
      for (int r = 0; r < protWidth; r++) begin
        if (best[r]) begin
          mat[r][d] = 1'b1;
        end
      end
    end
    return mat;
  endfunction

  // Turns the matrix into one correction code per codeword bit, which is that bit's column
  function automatic bit [MaxTotalWidth-1:0][MaxParityWidth-1:0] transpose(
    bit [MaxParityWidth-1:0][MaxTotalWidth-1:0] mat,
    int unsigned                                rows,
    int unsigned                                cols
  );
    bit [MaxTotalWidth-1:0][MaxParityWidth-1:0] res;

    res = '0;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        res[c][r] = mat[r][c];
      end
    end
    return res;
  endfunction

endpackage
